// File: rtl/riders_pkg.sv
// *************************************************************************
// Types and constants shared by the board logic around the main CPU.
// Import into a module body, or use scoped names in port lists.
// *************************************************************************
`default_nettype none

package riders_pkg;

    // Widest object RAM address that mem_req_t can carry
    localparam int ORAM_AW_MAX = 12;

    // Region select sits in address bits 15:14
    localparam int REGION_LSB = 14;

    typedef enum logic [2:0] {
        SSRIDERS = 3'd0,
        TMNT2    = 3'd1
    } game_id_e;

    typedef enum logic [1:0] {
        REG_ORAM = 2'd0,
        REG_PROT = 2'd1,
        REG_SND  = 2'd2,
        REG_CFG  = 2'd3
    } region_e;

    typedef enum logic [1:0] {
        PR_SRC  = 2'd0,
        PR_DST  = 2'd1,
        PR_CNT  = 2'd2,
        PR_CTRL = 2'd3
    } prot_reg_e;

    typedef enum logic [1:0] {
        DMA_IDLE,
        DMA_READ,
        DMA_WRITE,
        DMA_DONE
    } dma_state_e;

    // Wishbone classic, master to slave
    typedef struct packed {
        logic [15:0] adr;
        logic [15:0] dat;
        logic [1:0]  sel;
        logic        we;
        logic        cyc;
        logic        stb;
    } wb_req_t;

    typedef struct packed {
        logic [15:0] dat;
        logic        ack;
    } wb_rsp_t;

    // One object RAM access, we is per byte lane
    typedef struct packed {
        logic [ORAM_AW_MAX-1:0] addr;
        logic [15:0]            din;
        logic [1:0]             we;
        logic                   en;
    } mem_req_t;

endpackage

`default_nettype wire

// File: rtl/riders_bus_decode.sv
// *************************************************************************
// Wishbone slave for the main CPU. Splits cycles into four regions, times
// ack and arbitrates the object RAM between the CPU and the protection DMA.
// *************************************************************************
`default_nettype none

module riders_bus_decode #(
    parameter int ORAM_AW = 10
) (
    input  logic                 clk,
    input  logic                 arst_n,
    input  riders_pkg::wb_req_t  wb_req,
    output riders_pkg::wb_rsp_t  wb_rsp,
    output riders_pkg::mem_req_t cpu_mem,
    input  logic [15:0]          oram_q,
    input  logic                 bus_req,
    output logic                 bus_gnt,
    output logic                 reg_wr,
    output logic [1:0]           reg_addr,
    output logic [15:0]          reg_din,
    output logic                 prot_sel,
    output logic                 snd_sel,
    output logic                 cfg_sel,
    input  logic [15:0]          prot_dout,
    input  logic [7:0]           snd_dout,
    input  logic [7:0]           cfg_dout
);
    import riders_pkg::*;

    region_e region;
    logic    cyc_open;
    logic    reg_go;
    logic    ram_go;
    logic    ram_busy;

    assign region   = region_e'(wb_req.adr[REGION_LSB+1:REGION_LSB]);
    // Open until acked, the master drops stb the cycle after ack
    assign cyc_open = wb_req.cyc && wb_req.stb && !wb_rsp.ack;
    assign reg_go   = cyc_open && region != REG_ORAM;
    // RAM cycles wait while the DMA owns the RAM
    assign ram_go   = cyc_open && region == REG_ORAM && !ram_busy && !bus_gnt;

    assign reg_wr   = reg_go && wb_req.we;
    assign reg_addr = wb_req.adr[1:0];
    assign reg_din  = wb_req.dat;
    assign prot_sel = reg_go && region == REG_PROT;
    assign snd_sel  = reg_go && region == REG_SND;
    assign cfg_sel  = reg_go && region == REG_CFG;

    always_comb begin
        cpu_mem                   = '0;
        cpu_mem.addr[ORAM_AW-1:0] = wb_req.adr[ORAM_AW-1:0];
        cpu_mem.din               = wb_req.dat;
        cpu_mem.we                = wb_req.we ? wb_req.sel : 2'b00;
        cpu_mem.en                = ram_go;
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            wb_rsp   <= '0;
            ram_busy <= 1'b0;
            bus_gnt  <= 1'b0;
        end else begin
            wb_rsp.ack <= 1'b0;
            // Address cycle, then the RAM cycle that returns data
            ram_busy   <= ram_go;
            if (reg_go) begin
                wb_rsp.ack <= 1'b1;
                case (region)
                    REG_PROT: wb_rsp.dat <= prot_dout;
                    REG_SND:  wb_rsp.dat <= {8'h00, snd_dout};
                    default:  wb_rsp.dat <= {8'h00, cfg_dout};
                endcase
            end
            if (ram_busy) begin
                wb_rsp.ack <= 1'b1;
                wb_rsp.dat <= oram_q;
            end
            // Grant only between CPU RAM cycles, release when the DMA lets go
            if (bus_gnt) begin
                bus_gnt <= bus_req;
            end else begin
                bus_gnt <= bus_req && !ram_go && !ram_busy;
            end
        end
    end

endmodule

`default_nettype wire

// File: rtl/riders_oram.sv
// *************************************************************************
// Object RAM with byte lanes and a registered read. The DMA port is used
// while the bus is granted to it, the CPU port otherwise.
// *************************************************************************
`default_nettype none

module riders_oram #(
    parameter int ORAM_AW = 10
) (
    input  logic                 clk,
    input  logic                 bus_gnt,
    input  riders_pkg::mem_req_t cpu_mem,
    input  riders_pkg::mem_req_t dma_mem,
    output logic [15:0]          q
);
    import riders_pkg::*;

    logic [15:0]        mem [0:(1<<ORAM_AW)-1];
    mem_req_t           acc;
    logic [ORAM_AW-1:0] addr;

    assign acc  = bus_gnt ? dma_mem : cpu_mem;
    assign addr = acc.addr[ORAM_AW-1:0];

    always_ff @(posedge clk) begin
        if (acc.en) begin
            if (acc.we[0]) begin
                mem[addr][7:0] <= acc.din[7:0];
            end
            if (acc.we[1]) begin
                mem[addr][15:8] <= acc.din[15:8];
            end
            q <= mem[addr];
        end
    end

endmodule

`default_nettype wire

// File: rtl/riders_prot.sv
// *************************************************************************
// Protection chip. Copies object entries inside the object RAM by DMA and
// raises a latched interrupt when the copy ends.
// *************************************************************************
`default_nettype none

module riders_prot #(
    parameter int ORAM_AW = 10
) (
    input  logic                   clk,
    input  logic                   arst_n,
    input  riders_pkg::game_id_e   game_id,
    input  logic                   reg_wr,
    input  logic [1:0]             reg_addr,
    input  logic [15:0]            reg_din,
    input  logic                   prot_sel,
    output logic [15:0]            prot_dout,
    output logic                   bus_req,
    input  logic                   bus_gnt,
    output riders_pkg::mem_req_t   dma_mem,
    input  logic [15:0]            oram_q,
    output logic                   irq_n,
    output riders_pkg::dma_state_e state
);
    import riders_pkg::*;

    logic [ORAM_AW-1:0] src;
    logic [ORAM_AW-1:0] dst;
    logic [ORAM_AW:0]   cnt;
    logic               irq_pend;
    logic               wr_en;
    logic [15:0]        word;
    prot_reg_e          reg_sel;

    assign reg_sel = prot_reg_e'(reg_addr);
    assign wr_en   = reg_wr && prot_sel;
    assign irq_n   = !irq_pend;
    // TMNT2 stores object words with the bytes swapped
    assign word    = (game_id == TMNT2) ? {oram_q[7:0], oram_q[15:8]} : oram_q;

    always_comb begin
        case (reg_sel)
            PR_SRC:  prot_dout = 16'(src);
            PR_DST:  prot_dout = 16'(dst);
            PR_CNT:  prot_dout = 16'(cnt);
            default: prot_dout = {14'd0, irq_pend, state != DMA_IDLE};
        endcase
    end

    always_comb begin
        dma_mem = '0;
        case (state)
            DMA_READ: begin
                dma_mem.addr[ORAM_AW-1:0] = src;
                dma_mem.en                = bus_gnt;
            end
            DMA_WRITE: begin
                dma_mem.addr[ORAM_AW-1:0] = dst;
                dma_mem.din               = word;
                dma_mem.we                = 2'b11;
                dma_mem.en                = 1'b1;
            end
            default: dma_mem = '0;
        endcase
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state    <= DMA_IDLE;
            bus_req  <= 1'b0;
            irq_pend <= 1'b0;
            src      <= '0;
            dst      <= '0;
            cnt      <= '0;
        end else begin
            // Any control write acknowledges the interrupt
            if (wr_en && reg_sel == PR_CTRL) begin
                irq_pend <= 1'b0;
            end
            case (state)
                DMA_IDLE: begin
                    if (wr_en) begin
                        case (reg_sel)
                            PR_SRC: src <= reg_din[ORAM_AW-1:0];
                            PR_DST: dst <= reg_din[ORAM_AW-1:0];
                            PR_CNT: cnt <= reg_din[ORAM_AW:0];
                            default: begin
                                if (reg_din[0] && cnt == '0) begin
                                    state    <= DMA_DONE;
                                    irq_pend <= 1'b1;
                                end else if (reg_din[0]) begin
                                    state   <= DMA_READ;
                                    bus_req <= 1'b1;
                                end
                            end
                        endcase
                    end
                end
                DMA_READ: begin
                    if (bus_gnt) begin
                        state <= DMA_WRITE;
                    end
                end
                DMA_WRITE: begin
                    src <= src + 1'b1;
                    dst <= dst + 1'b1;
                    cnt <= cnt - 1'b1;
                    if (cnt == {{ORAM_AW{1'b0}}, 1'b1}) begin
                        state    <= DMA_DONE;
                        bus_req  <= 1'b0;
                        irq_pend <= 1'b1;
                    end else begin
                        state <= DMA_READ;
                    end
                end
                default: state <= DMA_IDLE;
            endcase
        end
    end

endmodule

`default_nettype wire

// File: rtl/riders_snd_pair.sv
// *************************************************************************
// Latch pair between the main CPU and the sound CPU, plus the sound irq
// *************************************************************************
`default_nettype none

module riders_snd_pair (
    input  logic        clk,
    input  logic        arst_n,
    input  logic        reg_wr,
    input  logic [1:0]  reg_addr,
    input  logic [7:0]  reg_din,
    input  logic        snd_sel,
    output logic [7:0]  snd_dout,
    output logic [7:0]  snd_latch,
    output logic        snd_irq,
    input  logic        snd_rd,
    input  logic [7:0]  snd_reply,
    input  logic        snd_reply_we
);

    logic [7:0] reply_q;
    logic       latch_wr;

    assign latch_wr = reg_wr && snd_sel && reg_addr == 2'd0;

    always_comb begin
        case (reg_addr)
            2'd0:    snd_dout = reply_q;
            2'd1:    snd_dout = {7'd0, snd_irq};
            default: snd_dout = 8'h00;
        endcase
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            snd_latch <= 8'h00;
            reply_q   <= 8'h00;
            snd_irq   <= 1'b0;
        end else begin
            if (snd_reply_we) begin
                reply_q <= snd_reply;
            end
            // A new command wins over a read of the old one
            if (latch_wr) begin
                snd_latch <= reg_din;
                snd_irq   <= 1'b1;
            end else if (snd_rd) begin
                snd_irq <= 1'b0;
            end
        end
    end

endmodule

`default_nettype wire

// File: rtl/riders_cfg.sv
// *************************************************************************
// Game variant from the download header, CPU readback and the debug mux
// *************************************************************************
`default_nettype none

module riders_cfg (
    input  logic                   clk,
    input  logic                   arst_n,
    input  logic [3:0]             prog_addr,
    input  logic [7:0]             prog_data,
    input  logic                   prog_we,
    input  logic                   header,
    output riders_pkg::game_id_e   game_id,
    input  logic                   cfg_sel,
    input  logic [1:0]             reg_addr,
    output logic [7:0]             cfg_dout,
    input  logic [1:0]             debug_sel,
    input  riders_pkg::dma_state_e prot_state,
    input  logic                   snd_irq,
    input  logic                   prot_irq_n,
    output logic [7:0]             debug_view
);
    import riders_pkg::*;

    assign cfg_dout = (cfg_sel && reg_addr == 2'd0) ? {5'd0, game_id} : 8'h00;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            game_id    <= SSRIDERS;
            debug_view <= 8'h00;
        end else begin
            // Variant code is byte 15 of the header, unknown codes run as SSRIDERS
            if (prog_we && header && prog_addr == 4'hf) begin
                game_id <= (prog_data == 8'(TMNT2)) ? TMNT2 : SSRIDERS;
            end
            case (debug_sel)
                2'd0:    debug_view <= {5'd0, game_id};
                2'd1:    debug_view <= {6'd0, prot_state};
                2'd2:    debug_view <= {6'd0, !prot_irq_n, snd_irq};
                default: debug_view <= 8'h00;
            endcase
        end
    end

endmodule

`default_nettype wire

// File: rtl/riders_game.sv
// *************************************************************************
// Board logic around the main CPU. The CPU drives the Wishbone port, the
// sound CPU and the ROM downloader use the side ports.
// *************************************************************************
`default_nettype none

module riders_game #(
    parameter int ORAM_AW = 10
) (
    input  logic                clk,
    input  logic                arst_n,
    input  riders_pkg::wb_req_t wb_req,
    output riders_pkg::wb_rsp_t wb_rsp,
    output logic                prot_irq_n,
    output logic [7:0]          snd_latch,
    output logic                snd_irq,
    input  logic                snd_rd,
    input  logic [7:0]          snd_reply,
    input  logic                snd_reply_we,
    input  logic [3:0]          prog_addr,
    input  logic [7:0]          prog_data,
    input  logic                prog_we,
    input  logic                header,
    input  logic [1:0]          debug_sel,
    output logic [7:0]          debug_view
);
    import riders_pkg::*;

    mem_req_t    cpu_mem;
    mem_req_t    dma_mem;
    logic [15:0] oram_q;
    logic        bus_req;
    logic        bus_gnt;
    logic        reg_wr;
    logic [1:0]  reg_addr;
    logic [15:0] reg_din;
    logic        prot_sel;
    logic        snd_sel;
    logic        cfg_sel;
    logic [15:0] prot_dout;
    logic [7:0]  snd_dout;
    logic [7:0]  cfg_dout;
    game_id_e    game_id;
    dma_state_e  prot_state;

    riders_bus_decode #(
        .ORAM_AW ( ORAM_AW )
    ) u_decode (
        .clk       ( clk       ),
        .arst_n    ( arst_n    ),
        .wb_req    ( wb_req    ),
        .wb_rsp    ( wb_rsp    ),
        .cpu_mem   ( cpu_mem   ),
        .oram_q    ( oram_q    ),
        .bus_req   ( bus_req   ),
        .bus_gnt   ( bus_gnt   ),
        .reg_wr    ( reg_wr    ),
        .reg_addr  ( reg_addr  ),
        .reg_din   ( reg_din   ),
        .prot_sel  ( prot_sel  ),
        .snd_sel   ( snd_sel   ),
        .cfg_sel   ( cfg_sel   ),
        .prot_dout ( prot_dout ),
        .snd_dout  ( snd_dout  ),
        .cfg_dout  ( cfg_dout  )
    );

    riders_oram #(
        .ORAM_AW ( ORAM_AW )
    ) u_oram (
        .clk     ( clk     ),
        .bus_gnt ( bus_gnt ),
        .cpu_mem ( cpu_mem ),
        .dma_mem ( dma_mem ),
        .q       ( oram_q  )
    );

    riders_prot #(
        .ORAM_AW ( ORAM_AW )
    ) u_prot (
        .clk       ( clk        ),
        .arst_n    ( arst_n     ),
        .game_id   ( game_id    ),
        .reg_wr    ( reg_wr     ),
        .reg_addr  ( reg_addr   ),
        .reg_din   ( reg_din    ),
        .prot_sel  ( prot_sel   ),
        .prot_dout ( prot_dout  ),
        .bus_req   ( bus_req    ),
        .bus_gnt   ( bus_gnt    ),
        .dma_mem   ( dma_mem    ),
        .oram_q    ( oram_q     ),
        .irq_n     ( prot_irq_n ),
        .state     ( prot_state )
    );

    riders_snd_pair u_snd (
        .clk          ( clk          ),
        .arst_n       ( arst_n       ),
        .reg_wr       ( reg_wr       ),
        .reg_addr     ( reg_addr     ),
        .reg_din      ( reg_din[7:0] ),
        .snd_sel      ( snd_sel      ),
        .snd_dout     ( snd_dout     ),
        .snd_latch    ( snd_latch    ),
        .snd_irq      ( snd_irq      ),
        .snd_rd       ( snd_rd       ),
        .snd_reply    ( snd_reply    ),
        .snd_reply_we ( snd_reply_we )
    );

    riders_cfg u_cfg (
        .clk        ( clk        ),
        .arst_n     ( arst_n     ),
        .prog_addr  ( prog_addr  ),
        .prog_data  ( prog_data  ),
        .prog_we    ( prog_we    ),
        .header     ( header     ),
        .game_id    ( game_id    ),
        .cfg_sel    ( cfg_sel    ),
        .reg_addr   ( reg_addr   ),
        .cfg_dout   ( cfg_dout   ),
        .debug_sel  ( debug_sel  ),
        .prot_state ( prot_state ),
        .snd_irq    ( snd_irq    ),
        .prot_irq_n ( prot_irq_n ),
        .debug_view ( debug_view )
    );

endmodule

`default_nettype wire

// File: tb/riders_game_tb.sv
// **************************************************************************
// Testbench for riders_game. Acts as the main CPU on the Wishbone port and
// checks RAM, DMA, sound latch and debug mux against a shadow model.
// **************************************************************************
`default_nettype none

module riders_game_tb;
    timeunit 1ns;
    timeprecision 100ps;
    import riders_pkg::*;

    localparam int ORAM_AW    = 10;
    localparam int DEPTH      = 1 << ORAM_AW;
    localparam int MASK       = DEPTH - 1;
    localparam int CLK_PERIOD = 4;
    localparam int N_RAM      = 48;
    localparam int MAX_CNT    = 32;
    // RAM fill, random accesses, three DMA runs with setup and readback, misc
    localparam int BUS_CYCLES = DEPTH + 2 * N_RAM + 3 * (MAX_CNT + 10) + 30;
    localparam int DMA_WORDS  = 3 * MAX_CNT;
    localparam int TIMEOUT_NS = 2 * (3 * BUS_CYCLES + 2 * DMA_WORDS + 20) * CLK_PERIOD;

    localparam logic [15:0] PROT_BASE = 16'h4000;
    localparam logic [15:0] SND_BASE  = 16'h8000;
    localparam logic [15:0] CFG_BASE  = 16'hc000;

    logic        clk;
    logic        arst_n;
    wb_req_t     wb_req;
    wb_rsp_t     wb_rsp;
    logic        prot_irq_n;
    logic [7:0]  snd_latch;
    logic        snd_irq;
    logic        snd_rd;
    logic [7:0]  snd_reply;
    logic        snd_reply_we;
    logic [3:0]  prog_addr;
    logic [7:0]  prog_data;
    logic        prog_we;
    logic        header;
    logic [1:0]  debug_sel;
    logic [7:0]  debug_view;

    // Shadow of the object RAM
    logic [15:0] shadow [0:DEPTH-1];
    integer      seed = 32'h83db;
    int          errors;
    int          checks;
    int          tests;
    int          bad_tests;
    int          mark;
    logic        tmnt2;

    riders_game #(
        .ORAM_AW ( ORAM_AW )
    ) UUT (
        .clk          ( clk          ),
        .arst_n       ( arst_n       ),
        .wb_req       ( wb_req       ),
        .wb_rsp       ( wb_rsp       ),
        .prot_irq_n   ( prot_irq_n   ),
        .snd_latch    ( snd_latch    ),
        .snd_irq      ( snd_irq      ),
        .snd_rd       ( snd_rd       ),
        .snd_reply    ( snd_reply    ),
        .snd_reply_we ( snd_reply_we ),
        .prog_addr    ( prog_addr    ),
        .prog_data    ( prog_data    ),
        .prog_we      ( prog_we      ),
        .header       ( header       ),
        .debug_sel    ( debug_sel    ),
        .debug_view   ( debug_view   )
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    initial begin
        #(TIMEOUT_NS);
        $display("Timeout: run did not finish within %0d ns", TIMEOUT_NS);
        $display("test failed");
        $finish;
    end

    // Inputs change 1 ns after the rising edge
    task automatic step();
        @(posedge clk);
        #1;
    endtask

    task automatic compare(input logic [15:0] got, input logic [15:0] exp, input string what);
        checks++;
        if (got !== exp) begin
            $display("Error at %0d ns: %s, got %h, expected %h", $time, what, got, exp);
            errors++;
        end
    endtask

    task automatic bus_write(input logic [15:0] adr, input logic [15:0] dat,
                             input logic [1:0] sel);
        wb_req.adr = adr;
        wb_req.dat = dat;
        wb_req.sel = sel;
        wb_req.we  = 1'b1;
        wb_req.cyc = 1'b1;
        wb_req.stb = 1'b1;
        step();
        while (!wb_rsp.ack) begin
            step();
        end
        wb_req.cyc = 1'b0;
        wb_req.stb = 1'b0;
        wb_req.we  = 1'b0;
    endtask

    task automatic bus_read(input logic [15:0] adr, output logic [15:0] dat);
        wb_req.adr = adr;
        wb_req.sel = 2'b11;
        wb_req.we  = 1'b0;
        wb_req.cyc = 1'b1;
        wb_req.stb = 1'b1;
        step();
        while (!wb_rsp.ack) begin
            step();
        end
        dat        = wb_rsp.dat;
        wb_req.cyc = 1'b0;
        wb_req.stb = 1'b0;
    endtask

    task automatic load_header(input logic [3:0] addr, input logic [7:0] data);
        prog_addr = addr;
        prog_data = data;
        prog_we   = 1'b1;
        header    = 1'b1;
        step();
        prog_we   = 1'b0;
        header    = 1'b0;
    endtask

    task automatic start_dma(input int src, input int dst, input int cnt);
        logic [15:0] w;
        bus_write(PROT_BASE + 16'(PR_SRC), 16'(src), 2'b11);
        bus_write(PROT_BASE + 16'(PR_DST), 16'(dst), 2'b11);
        bus_write(PROT_BASE + 16'(PR_CNT), 16'(cnt), 2'b11);
        // Word by word, so overlapping ranges come out as on the board
        for (int i = 0; i < cnt; i++) begin
            w = shadow[(src + i) & MASK];
            shadow[(dst + i) & MASK] = tmnt2 ? {w[7:0], w[15:8]} : w;
        end
        bus_write(PROT_BASE + 16'(PR_CTRL), 16'h0001, 2'b11);
    endtask

    task automatic wait_dma_done();
        while (prot_irq_n) begin
            step();
        end
        // One more cycle until the engine is idle again
        step();
    endtask

    task automatic release_dma();
        logic [15:0] d;
        bus_read(PROT_BASE + 16'(PR_CTRL), d);
        compare(d, 16'h0002, "PR_CTRL after copy");
        compare(16'(prot_irq_n), 16'h0000, "prot_irq_n held low");
        bus_write(PROT_BASE + 16'(PR_CTRL), 16'h0000, 2'b11);
        compare(16'(prot_irq_n), 16'h0001, "prot_irq_n after release");
    endtask

    task automatic check_copy(input int dst, input int cnt, input string what);
        logic [15:0] d;
        int          a;
        for (int i = 0; i < cnt; i++) begin
            a = (dst + i) & MASK;
            bus_read(16'(a), d);
            compare(d, shadow[a], $sformatf("%s, word %0d", what, a));
        end
    endtask

    task automatic end_test(input string name);
        tests++;
        if (errors == mark) begin
            $display("Test %0d, %s: ok", tests, name);
        end else begin
            bad_tests++;
            $display("Test %0d, %s: %0d mismatches", tests, name, errors - mark);
        end
        mark = errors;
    endtask

    initial begin
        logic [15:0] d;
        logic [15:0] w;
        int          a;
        int          r;
        int          src;
        int          dst;
        int          cnt;
        int          addr_q[$];

        wb_req       = '0;
        arst_n       = 1'b0;
        snd_rd       = 1'b0;
        snd_reply    = 8'h00;
        snd_reply_we = 1'b0;
        prog_addr    = 4'h0;
        prog_data    = 8'h00;
        prog_we      = 1'b0;
        header       = 1'b0;
        debug_sel    = 2'd0;
        tmnt2        = 1'b0;
        errors       = 0;
        checks       = 0;
        tests        = 0;
        bad_tests    = 0;
        mark         = 0;
        repeat (5) @(posedge clk);
        #1;
        // Reset values, sampled while reset is still applied
        compare(16'(wb_rsp.ack), 16'h0000, "ack in reset");
        compare(16'(prot_irq_n), 16'h0001, "prot_irq_n in reset");
        compare(16'(snd_irq), 16'h0000, "snd_irq in reset");
        arst_n = 1'b1;
        step();
        end_test("Reset values");

        // Known contents everywhere so every DMA source is defined
        for (a = 0; a < DEPTH; a++) begin
            w = 16'(a * 40503) ^ 16'ha5c3;
            bus_write(16'(a), w, 2'b11);
            shadow[a] = w;
        end
        for (int i = 0; i < N_RAM; i++) begin
            a = $random(seed) & MASK;
            w = $random(seed);
            r = $random(seed);
            bus_write(16'(a), w, r[1:0]);
            if (r[0]) begin
                shadow[a][7:0] = w[7:0];
            end
            if (r[1]) begin
                shadow[a][15:8] = w[15:8];
            end
            addr_q.push_back(a);
        end
        foreach (addr_q[i]) begin
            bus_read(16'(addr_q[i]), d);
            compare(d, shadow[addr_q[i]], $sformatf("ORAM word %0d", addr_q[i]));
        end
        end_test("ORAM random byte writes");

        src = $random(seed) & MASK;
        dst = $random(seed) & MASK;
        cnt = 1 + ($random(seed) & (MAX_CNT - 1));
        start_dma(src, dst, cnt);
        wait_dma_done();
        release_dma();
        check_copy(dst, cnt, "plain copy");
        end_test("DMA under SSRIDERS");

        // Only header byte 15 carries the variant
        load_header(4'he, 8'h01);
        bus_read(CFG_BASE, d);
        compare(d, 16'h0000, "variant after other header byte");
        load_header(4'hf, 8'h01);
        tmnt2 = 1'b1;
        bus_read(CFG_BASE, d);
        compare(d, 16'h0001, "variant readback");
        src = $random(seed) & MASK;
        dst = $random(seed) & MASK;
        cnt = 1 + ($random(seed) & (MAX_CNT - 1));
        start_dma(src, dst, cnt);
        wait_dma_done();
        release_dma();
        check_copy(dst, cnt, "swapped copy");
        end_test("DMA under TMNT2");

        src = $random(seed) & MASK;
        dst = $random(seed) & MASK;
        cnt = 8 + ($random(seed) & 15);
        start_dma(src, dst, cnt);
        // Last destination word changes at the very end of the copy
        a = (dst + cnt - 1) & MASK;
        bus_read(16'(a), d);
        compare(16'(prot_irq_n), 16'h0000, "copy ended before read ack");
        compare(d, shadow[a], "read stalled behind DMA");
        wait_dma_done();
        release_dma();
        check_copy(dst, cnt, "copy under CPU read");
        end_test("CPU read during DMA");

        w = $random(seed) & 16'h00ff;
        bus_write(SND_BASE, w, 2'b11);
        compare(16'(snd_latch), w, "snd_latch");
        compare(16'(snd_irq), 16'h0001, "snd_irq after command");
        bus_read(SND_BASE + 16'd1, d);
        compare(d, 16'h0001, "snd_irq readback");
        snd_rd = 1'b1;
        step();
        snd_rd = 1'b0;
        compare(16'(snd_irq), 16'h0000, "snd_irq after snd_rd");
        w = $random(seed) & 16'h00ff;
        snd_reply    = w[7:0];
        snd_reply_we = 1'b1;
        step();
        snd_reply_we = 1'b0;
        bus_read(SND_BASE, d);
        compare(d, w, "reply readback");
        end_test("Sound latch pair");

        // Raise both interrupt flags, the zero count one without RAM access
        bus_write(SND_BASE, 16'h005a, 2'b11);
        bus_write(PROT_BASE + 16'(PR_CNT), 16'h0000, 2'b11);
        bus_write(PROT_BASE + 16'(PR_CTRL), 16'h0001, 2'b11);
        compare(16'(prot_irq_n), 16'h0000, "zero count irq");
        step();
        for (int s = 0; s < 4; s++) begin
            debug_sel = 2'(s);
            step();
            case (s)
                0:       w = tmnt2 ? 16'h0001 : 16'h0000;
                2:       w = 16'h0003;
                default: w = 16'h0000;
            endcase
            compare(16'(debug_view), w, $sformatf("debug_view sel %0d", s));
        end
        bus_write(PROT_BASE + 16'(PR_CTRL), 16'h0000, 2'b11);
        end_test("Debug view mux");

        $display("Summary: %0d tests, %0d with mismatches, %0d checks, %0d errors",
                 tests, bad_tests, checks, errors);
        if (errors == 0) begin
            $display("test passed");
        end else begin
            $display("test failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: riders.f
rtl/riders_pkg.sv
rtl/riders_bus_decode.sv
rtl/riders_oram.sv
rtl/riders_prot.sv
rtl/riders_snd_pair.sv
rtl/riders_cfg.sv
rtl/riders_game.sv
tb/riders_game_tb.sv

// File: Bender.yml
package:
  name: riders

sources:
  - rtl/riders_pkg.sv
  - rtl/riders_bus_decode.sv
  - rtl/riders_oram.sv
  - rtl/riders_prot.sv
  - rtl/riders_snd_pair.sv
  - rtl/riders_cfg.sv
  - rtl/riders_game.sv
  - target: test
    files:
      - tb/riders_game_tb.sv
